// ==== source/issue_pkg.sv ====
/* issue stage shared types */

package issue_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned REG_ADDR_BITS = 5;
    localparam int unsigned TRANS_ID_BITS = 3;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

    // ------------------------------------------------------------------
    // functional units and operators
    // ------------------------------------------------------------------
    // NONE in the clobber list marks a register with no pending write
    typedef enum logic [2:0] {
        NONE, ALU, CTRL_FLOW, MULT, LOAD, STORE, CSR
    } fu_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND_OP, OR_OP, MUL, LW, SW, BEQ, JAL, CSRRW
    } fu_op_t;

    // pending writer unit for every integer register
    typedef fu_t [2**REG_ADDR_BITS-1:0] clobber_t;

    // ------------------------------------------------------------------
    // stage payloads
    // ------------------------------------------------------------------
    // decoded instruction as handed over by the scoreboard
    typedef struct packed {
        xlen_t     pc;
        fu_t       fu;
        fu_op_t    op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        // immediate value
        xlen_t     result;
        logic      use_imm;
        logic      use_pc;
        logic      use_zimm;
        // exception already raised upstream
        logic      ex_valid;
        trans_id_t trans_id;
    } issue_instr_t;

    // operand bundle for the execute units
    typedef struct packed {
        fu_t       fu;
        fu_op_t    op;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    // one commit stage write port
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        xlen_t     wdata;
    } commit_port_t;

endpackage

// ==== source/int_regfile.sv ====
/* integer register file */

`timescale 1ns/1ps

module int_regfile #(
    parameter int unsigned NrCommitPorts = 2
) (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    // read side, addressed by rs1 and rs2
    input  issue_pkg::reg_addr_t                      raddr_a_i,
    input  issue_pkg::reg_addr_t                      raddr_b_i,
    output issue_pkg::xlen_t                          rdata_a_o,
    output issue_pkg::xlen_t                          rdata_b_o,
    // write side from the commit stage
    input  issue_pkg::commit_port_t [NrCommitPorts-1:0] commit_i
);

    import issue_pkg::*;

    // x1 to x31 only, x0 has no storage
    xlen_t [2**REG_ADDR_BITS-1:1] mem_q;

    // ------------------------------------------------------------------
    // write ports
    // ------------------------------------------------------------------
    // ports are walked upwards so the highest port wins a collision
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_q <= '0;
        end else begin
            for (int unsigned p = 0; p < NrCommitPorts; p++) begin
                // writes to x0 are dropped
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    mem_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // read ports
    // ------------------------------------------------------------------
    // combinational, x0 reads as zero
    always_comb begin
        rdata_a_o = '0;
        rdata_b_o = '0;
        if (raddr_a_i != '0) begin
            rdata_a_o = mem_q[raddr_a_i];
        end
        if (raddr_b_i != '0) begin
            rdata_b_o = mem_q[raddr_b_i];
        end
    end

endmodule

// ==== source/operand_hazard.sv ====
/* source operand hazard check */

`timescale 1ns/1ps

module operand_hazard (
    // instruction under issue
    input  issue_pkg::issue_instr_t issue_instr_i,
    // pending writers from the scoreboard
    input  issue_pkg::clobber_t     rd_clobber_i,
    // scoreboard has the result ready for forwarding
    input  logic                    rs1_valid_i,
    input  logic                    rs2_valid_i,
    // operand select controls
    output logic                    forward_rs1_o,
    output logic                    forward_rs2_o,
    // operand not yet available
    output logic                    stall_o
);

    import issue_pkg::*;

    fu_t rs1_writer;
    fu_t rs2_writer;

    // unit that will still write each source register
    assign rs1_writer = rd_clobber_i[issue_instr_i.rs1];
    assign rs2_writer = rd_clobber_i[issue_instr_i.rs2];

    // ------------------------------------------------------------------
    // forward or stall per operand
    // ------------------------------------------------------------------
    always_comb begin
        forward_rs1_o = 1'b0;
        forward_rs2_o = 1'b0;
        stall_o       = 1'b0;

        // rs1 holds an immediate for zimm, nothing to wait on then
        if (!issue_instr_i.use_zimm && (rs1_writer != NONE)) begin
            // CSR results only ever reach us through the register file
            if (rs1_valid_i && (rs1_writer != CSR)) begin
                forward_rs1_o = 1'b1;
            end else begin
                stall_o = 1'b1;
            end
        end

        // rs2 is always a register number
        if (rs2_writer != NONE) begin
            if (rs2_valid_i && (rs2_writer != CSR)) begin
                forward_rs2_o = 1'b1;
            end else begin
                stall_o = 1'b1;
            end
        end
    end

endmodule

// ==== source/issue_ctrl.sv ====
/* issue control and unit valid pulses */

`timescale 1ns/1ps

module issue_ctrl #(
    parameter int unsigned NrCommitPorts = 2
) (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        flush_i,
    // instruction from the scoreboard, held until acknowledged
    input  issue_pkg::issue_instr_t                     issue_instr_i,
    input  logic                                        issue_instr_valid_i,
    input  issue_pkg::clobber_t                         rd_clobber_i,
    // commit writes of this cycle free a clobbered rd
    input  issue_pkg::commit_port_t [NrCommitPorts-1:0] commit_i,
    // from the operand hazard check
    input  logic                                        stall_i,
    // execute unit readiness
    input  logic                                        flu_ready_i,
    input  logic                                        lsu_ready_i,
    output logic                                        issue_ack_o,
    // one cycle pulses to the execute units
    output logic                                        alu_valid_o,
    output logic                                        branch_valid_o,
    output logic                                        mult_valid_o,
    output logic                                        lsu_valid_o,
    output logic                                        csr_valid_o
);

    import issue_pkg::*;

    logic fu_busy;
    logic rd_free;
    logic issue_go;

    // ------------------------------------------------------------------
    // unit busy select
    // ------------------------------------------------------------------
    always_comb begin
        case (issue_instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // write after write check
    // ------------------------------------------------------------------
    // rd is free with no pending writer, or when commit writes it now
    always_comb begin
        rd_free = (rd_clobber_i[issue_instr_i.rd] == NONE);
        for (int unsigned p = 0; p < NrCommitPorts; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
                rd_free = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // acknowledge
    // ------------------------------------------------------------------
    always_comb begin
        issue_go = !stall_i && !fu_busy && rd_free;
        // exceptions and unit-less instructions never wait
        if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
            issue_go = 1'b1;
        end
        issue_ack_o = issue_instr_valid_i && issue_go;
        // the fixed latency result bus only takes a MULT after a MULT
        if (mult_valid_o && (issue_instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // unit valid pulses
    // ------------------------------------------------------------------
    // one pulse per transfer, none for an exception, none on flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            mult_valid_o   <= 1'b0;
            lsu_valid_o    <= 1'b0;
            csr_valid_o    <= 1'b0;
        end else begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            mult_valid_o   <= 1'b0;
            lsu_valid_o    <= 1'b0;
            csr_valid_o    <= 1'b0;
            if (issue_instr_valid_i && issue_ack_o && !issue_instr_i.ex_valid && !flush_i) begin
                case (issue_instr_i.fu)
                    ALU:         alu_valid_o    <= 1'b1;
                    CTRL_FLOW:   branch_valid_o <= 1'b1;
                    MULT:        mult_valid_o   <= 1'b1;
                    LOAD, STORE: lsu_valid_o    <= 1'b1;
                    CSR:         csr_valid_o    <= 1'b1;
                    default:     ;
                endcase
            end
        end
    end

endmodule

// ==== source/operand_select.sv ====
/* operand mux and stage register */

`timescale 1ns/1ps

module operand_select (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  issue_pkg::issue_instr_t issue_instr_i,
    // register file read data
    input  issue_pkg::xlen_t        rdata_a_i,
    input  issue_pkg::xlen_t        rdata_b_i,
    // scoreboard forwarding data
    input  issue_pkg::xlen_t        rs1_i,
    input  issue_pkg::xlen_t        rs2_i,
    input  logic                    forward_rs1_i,
    input  logic                    forward_rs2_i,
    // registered operands to the execute stage
    output issue_pkg::fu_data_t     fu_data_o
);

    import issue_pkg::*;

    fu_data_t fu_data_d;

    // ------------------------------------------------------------------
    // forwarding and operand mux
    // ------------------------------------------------------------------
    always_comb begin
        fu_data_d.fu       = issue_instr_i.fu;
        fu_data_d.op       = issue_instr_i.op;
        fu_data_d.imm      = issue_instr_i.result;
        fu_data_d.trans_id = issue_instr_i.trans_id;

        // register file by default
        fu_data_d.operand_a = rdata_a_i;
        fu_data_d.operand_b = rdata_b_i;

        // result still in flight in the scoreboard
        if (forward_rs1_i) begin
            fu_data_d.operand_a = rs1_i;
        end
        if (forward_rs2_i) begin
            fu_data_d.operand_b = rs2_i;
        end

        // auipc and jumps take the pc
        if (issue_instr_i.use_pc) begin
            fu_data_d.operand_a = issue_instr_i.pc;
        end
        // csr immediate form, zero extended rs1 field
        if (issue_instr_i.use_zimm) begin
            fu_data_d.operand_a = {{(XLEN-REG_ADDR_BITS){1'b0}}, issue_instr_i.rs1};
        end

        // stores and branches keep rs2 and read the immediate from imm
        if (issue_instr_i.use_imm && (issue_instr_i.fu != STORE)
                && (issue_instr_i.fu != CTRL_FLOW)) begin
            fu_data_d.operand_b = issue_instr_i.result;
        end
    end

    // ------------------------------------------------------------------
    // issue to execute register
    // ------------------------------------------------------------------
    // loads every cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o <= '{fu: NONE, op: ADD, operand_a: '0, operand_b: '0,
                           imm: '0, trans_id: '0};
        end else begin
            fu_data_o <= fu_data_d;
        end
    end

endmodule

// ==== source/issue_read_operands.sv ====
/* issue and operand read stage */

`timescale 1ns/1ps

module issue_read_operands #(
    parameter int unsigned NrCommitPorts = 2
) (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        flush_i,
    // instruction from the scoreboard
    input  issue_pkg::issue_instr_t                     issue_instr_i,
    input  logic                                        issue_instr_valid_i,
    output logic                                        issue_ack_o,
    // scoreboard lookup of the source operands
    output issue_pkg::reg_addr_t                        rs1_o,
    input  issue_pkg::xlen_t                            rs1_i,
    input  logic                                        rs1_valid_i,
    output issue_pkg::reg_addr_t                        rs2_o,
    input  issue_pkg::xlen_t                            rs2_i,
    input  logic                                        rs2_valid_i,
    input  issue_pkg::clobber_t                         rd_clobber_i,
    // to the execute units
    output issue_pkg::fu_data_t                         fu_data_o,
    input  logic                                        flu_ready_i,
    input  logic                                        lsu_ready_i,
    output logic                                        alu_valid_o,
    output logic                                        branch_valid_o,
    output logic                                        mult_valid_o,
    output logic                                        lsu_valid_o,
    output logic                                        csr_valid_o,
    // commit stage writes
    input  issue_pkg::commit_port_t [NrCommitPorts-1:0] commit_i
);

    import issue_pkg::*;

    xlen_t rdata_a;
    xlen_t rdata_b;
    logic  forward_rs1;
    logic  forward_rs2;
    logic  stall;

    // scoreboard is polled with the instruction's sources
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    // ------------------------------------------------------------------
    // register file
    // ------------------------------------------------------------------
    int_regfile #(
        .NrCommitPorts (NrCommitPorts)
    ) u_int_regfile (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_instr_i.rs1),
        .raddr_b_i (issue_instr_i.rs2),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .commit_i  (commit_i)
    );

    // ------------------------------------------------------------------
    // hazard check, issue control, operand select
    // ------------------------------------------------------------------
    operand_hazard u_operand_hazard (
        .issue_instr_i (issue_instr_i),
        .rd_clobber_i  (rd_clobber_i),
        .rs1_valid_i   (rs1_valid_i),
        .rs2_valid_i   (rs2_valid_i),
        .forward_rs1_o (forward_rs1),
        .forward_rs2_o (forward_rs2),
        .stall_o       (stall)
    );

    issue_ctrl #(
        .NrCommitPorts (NrCommitPorts)
    ) u_issue_ctrl (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .issue_instr_i       (issue_instr_i),
        .issue_instr_valid_i (issue_instr_valid_i),
        .rd_clobber_i        (rd_clobber_i),
        .commit_i            (commit_i),
        .stall_i             (stall),
        .flu_ready_i         (flu_ready_i),
        .lsu_ready_i         (lsu_ready_i),
        .issue_ack_o         (issue_ack_o),
        .alu_valid_o         (alu_valid_o),
        .branch_valid_o      (branch_valid_o),
        .mult_valid_o        (mult_valid_o),
        .lsu_valid_o         (lsu_valid_o),
        .csr_valid_o         (csr_valid_o)
    );

    operand_select u_operand_select (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .issue_instr_i (issue_instr_i),
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .forward_rs1_i (forward_rs1),
        .forward_rs2_i (forward_rs2),
        .fu_data_o     (fu_data_o)
    );

endmodule

// ==== testbench/issue_read_operands_asserts.sv ====
/* issue stage protocol checks */

`timescale 1ns/1ps

module issue_read_operands_asserts (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    flush_i,
    input issue_pkg::issue_instr_t issue_instr_i,
    input logic                    issue_instr_valid_i,
    input logic                    issue_ack_o,
    input logic                    alu_valid_o,
    input logic                    branch_valid_o,
    input logic                    mult_valid_o,
    input logic                    lsu_valid_o,
    input logic                    csr_valid_o
);

    import issue_pkg::*;

    logic [4:0] pulses;
    logic       transfer;

    assign pulses   = {alu_valid_o, branch_valid_o, mult_valid_o, lsu_valid_o, csr_valid_o};
    assign transfer = issue_instr_valid_i && issue_ack_o;

    // ------------------------------------------------------------------
    // acknowledge and pulses
    // ------------------------------------------------------------------
    pulses_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(pulses))
        else $error("more than one unit valid pulse high");

    // a clean transfer to a real unit is followed by exactly one pulse
    pulse_after_transfer: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (transfer && !issue_instr_i.ex_valid && !flush_i && issue_instr_i.fu != NONE)
        |=> $onehot(pulses))
        else $error("no unit valid pulse after a transfer");

    // no transfer, or an exception, gives no pulse
    no_pulse_without_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!transfer || issue_instr_i.ex_valid) |=> (pulses == '0))
        else $error("unit valid pulse without an issued instruction");

    flush_clears_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> (pulses == '0))
        else $error("unit valid pulse after a flush");

    // first cycle out of reset starts with every pulse low
    pulses_low_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> (pulses == '0))
        else $error("unit valid pulse high right after reset");

endmodule

// ==== testbench/tb_issue_read_operands.sv ====
/* issue stage testbench */

`timescale 1ns/1ps

module tb_issue_read_operands;

    import issue_pkg::*;

    localparam int unsigned NR_PORTS    = 2;
    localparam int unsigned NUM_TESTS   = 400;
    localparam int unsigned CYCLE_LIMIT = NUM_TESTS * 4 + 50;

    // expected response for one cycle of inputs
    typedef struct packed {
        logic      ack;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        fu_data_t  data;
        fu_t       pulse;
    } expect_t;

    logic                         clk_i;
    logic                         rst_ni;
    logic                         flush;
    issue_instr_t                 instr;
    logic                         instr_valid;
    logic                         issue_ack;
    reg_addr_t                    rs1_addr;
    reg_addr_t                    rs2_addr;
    xlen_t                        rs1_data;
    xlen_t                        rs2_data;
    logic                         rs1_valid;
    logic                         rs2_valid;
    clobber_t                     clobber;
    fu_data_t                     fu_data;
    logic                         flu_ready;
    logic                         lsu_ready;
    logic                         alu_valid;
    logic                         branch_valid;
    logic                         mult_valid;
    logic                         lsu_valid;
    logic                         csr_valid;
    commit_port_t [NR_PORTS-1:0]  commit;

    // shadow register file with x0 kept at zero
    xlen_t       shadow [2**REG_ADDR_BITS];
    logic [31:0] rng;
    int unsigned cycles;
    int unsigned ack_errors;
    int unsigned addr_errors;
    int unsigned data_errors;
    int unsigned pulse_errors;
    logic        ack_seen;
    expect_t     prev_exp;
    expect_t     cur_exp;

    issue_read_operands #(
        .NrCommitPorts (NR_PORTS)
    ) UUT (
        .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush),
        .issue_instr_i (instr), .issue_instr_valid_i (instr_valid), .issue_ack_o (issue_ack),
        .rs1_o (rs1_addr), .rs1_i (rs1_data), .rs1_valid_i (rs1_valid),
        .rs2_o (rs2_addr), .rs2_i (rs2_data), .rs2_valid_i (rs2_valid),
        .rd_clobber_i (clobber), .fu_data_o (fu_data),
        .flu_ready_i (flu_ready), .lsu_ready_i (lsu_ready),
        .alu_valid_o (alu_valid), .branch_valid_o (branch_valid), .mult_valid_o (mult_valid),
        .lsu_valid_o (lsu_valid), .csr_valid_o (csr_valid), .commit_i (commit)
    );

    bind issue_read_operands issue_read_operands_asserts u_asserts (
        .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush_i),
        .issue_instr_i (issue_instr_i), .issue_instr_valid_i (issue_instr_valid_i),
        .issue_ack_o (issue_ack_o), .alu_valid_o (alu_valid_o),
        .branch_valid_o (branch_valid_o), .mult_valid_o (mult_valid_o),
        .lsu_valid_o (lsu_valid_o), .csr_valid_o (csr_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // random source
    // ------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    function automatic expect_t expected_result(
        input issue_instr_t ins, input logic valid, input clobber_t clb,
        input logic v1, input logic v2, input xlen_t d1, input xlen_t d2,
        input logic flu_rdy, input logic lsu_rdy,
        input commit_port_t [NR_PORTS-1:0] cmt, input logic flsh, input logic last_mult);
        expect_t e;
        logic    f1;
        logic    f2;
        logic    stall;
        logic    busy;
        logic    rd_free;
        f1    = 1'b0;
        f2    = 1'b0;
        stall = 1'b0;
        // CSR writers are never forwarded
        if (!ins.use_zimm && clb[ins.rs1] != NONE) begin
            if (v1 && clb[ins.rs1] != CSR) f1 = 1'b1;
            else stall = 1'b1;
        end
        if (clb[ins.rs2] != NONE) begin
            if (v2 && clb[ins.rs2] != CSR) f2 = 1'b1;
            else stall = 1'b1;
        end
        busy = (ins.fu == LOAD || ins.fu == STORE) ? !lsu_rdy : (ins.fu != NONE) && !flu_rdy;
        rd_free = (clb[ins.rd] == NONE);
        for (int p = 0; p < NR_PORTS; p++) begin
            if (cmt[p].we && cmt[p].waddr == ins.rd) rd_free = 1'b1;
        end
        e.ack = valid && ((!stall && !busy && rd_free) || ins.ex_valid || ins.fu == NONE);
        if (last_mult && ins.fu != MULT) e.ack = 1'b0;
        e.pulse = (e.ack && !ins.ex_valid && !flsh) ? ins.fu : NONE;
        // scoreboard lookup uses the instruction's own sources
        e.rs1_addr = ins.rs1;
        e.rs2_addr = ins.rs2;
        // zimm wins over pc, pc over forward, forward over register file
        if (ins.use_zimm) e.data.operand_a = {{(XLEN-REG_ADDR_BITS){1'b0}}, ins.rs1};
        else if (ins.use_pc) e.data.operand_a = ins.pc;
        else if (f1) e.data.operand_a = d1;
        else e.data.operand_a = shadow[ins.rs1];
        if (ins.use_imm && ins.fu != STORE && ins.fu != CTRL_FLOW) e.data.operand_b = ins.result;
        else if (f2) e.data.operand_b = d2;
        else e.data.operand_b = shadow[ins.rs2];
        e.data.fu       = ins.fu;
        e.data.op       = ins.op;
        e.data.imm      = ins.result;
        e.data.trans_id = ins.trans_id;
        return e;
    endfunction

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic check_ack(input logic got, input logic exp);
        if (got !== exp) begin
            ack_errors++;
            $display("MISMATCH t=%0t issue_ack_o got %b exp %b", $time, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            addr_errors++;
            $display("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_fu_data(input fu_data_t got, input fu_data_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("MISMATCH t=%0t fu_data_o got %h exp %h", $time, got, exp);
        end
    endtask

    // pulse order alu, branch, mult, lsu, csr
    task automatic check_pulses(input fu_t exp);
        logic [4:0] got;
        logic [4:0] want;
        got = {alu_valid, branch_valid, mult_valid, lsu_valid, csr_valid};
        case (exp)
            ALU:         want = 5'b10000;
            CTRL_FLOW:   want = 5'b01000;
            MULT:        want = 5'b00100;
            LOAD, STORE: want = 5'b00010;
            CSR:         want = 5'b00001;
            default:     want = 5'b00000;
        endcase
        if (got !== want) begin
            pulse_errors++;
            $display("MISMATCH t=%0t unit valid pulses got %b exp %b", $time, got, want);
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    // the decoder holds an unacknowledged instruction while everything else changes
    task automatic drive_cycle();
        logic [31:0]                 r;
        issue_instr_t                ins;
        clobber_t                    clb;
        commit_port_t [NR_PORTS-1:0] cmt;
        r = rand_word();
        if (!(instr_valid && !ack_seen)) begin
            ins.pc       = rand_word();
            ins.result   = rand_word();
            ins.fu       = fu_t'(r[2:0] % 3'd7);
            ins.op       = fu_op_t'(r[6:3] % 4'd10);
            ins.rs1      = {2'b00, r[9:7]};
            ins.rs2      = {2'b00, r[12:10]};
            ins.rd       = {2'b00, r[15:13]};
            ins.use_imm  = r[16];
            ins.use_pc   = r[17] & r[18];
            ins.use_zimm = (r[20:19] == 2'b00);
            ins.ex_valid = (r[24:21] == 4'h0);
            ins.trans_id = r[27:25];
            instr       <= ins;
            instr_valid <= (r[29:28] != 2'b00);
        end
        // roughly a third of the registers have a pending writer
        for (int j = 0; j < 2**REG_ADDR_BITS; j++) begin
            r      = rand_word();
            clb[j] = (r[3:0] < 4'd5) ? fu_t'(r[6:4] % 3'd7) : NONE;
        end
        for (int p = 0; p < NR_PORTS; p++) begin
            r              = rand_word();
            cmt[p].we      = r[0];
            cmt[p].waddr   = {2'b00, r[3:1]};
            cmt[p].wdata   = rand_word();
        end
        r = rand_word();
        clobber   <= clb;
        commit    <= cmt;
        rs1_valid <= (r[1:0] != 2'b00);
        rs2_valid <= (r[3:2] != 2'b00);
        flu_ready <= (r[6:4] != 3'b000);
        lsu_ready <= (r[9:7] != 3'b000);
        flush     <= (r[13:10] == 4'h0);
        rs1_data  <= rand_word();
        rs2_data  <= rand_word();
    endtask

    // shadow copy follows the driven commit ports with the higher port written last
    always @(posedge clk_i) begin
        if (rst_ni) begin
            for (int p = 0; p < NR_PORTS; p++) begin
                if (commit[p].we && commit[p].waddr != '0) begin
                    shadow[commit[p].waddr] = commit[p].wdata;
                end
            end
        end
    end

    // ack and lookup addresses in their own cycle, data and pulses one cycle later
    always @(negedge clk_i) begin
        if (rst_ni) begin
            cur_exp = expected_result(instr, instr_valid, clobber, rs1_valid, rs2_valid,
                                      rs1_data, rs2_data, flu_ready, lsu_ready, commit, flush,
                                      prev_exp.pulse == MULT);
            check_ack(issue_ack, cur_exp.ack);
            check_addr("rs1_o", rs1_addr, cur_exp.rs1_addr);
            check_addr("rs2_o", rs2_addr, cur_exp.rs2_addr);
            check_fu_data(fu_data, prev_exp.data);
            check_pulses(prev_exp.pulse);
            ack_seen = issue_ack;
            prev_exp = cur_exp;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, test sequence did not finish", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        rng          = 32'h5930_ae2f;
        cycles       = 0;
        ack_errors   = 0;
        addr_errors  = 0;
        data_errors  = 0;
        pulse_errors = 0;
        ack_seen     = 1'b0;
        // stage register and pulses show their reset values in the first cycle
        prev_exp         = '0;
        prev_exp.data.fu = NONE;
        prev_exp.data.op = ADD;
        prev_exp.pulse   = NONE;
        rst_ni       = 1'b0;
        flush        = 1'b0;
        instr        = '0;
        instr_valid  = 1'b0;
        rs1_data     = '0;
        rs2_data     = '0;
        rs1_valid    = 1'b0;
        rs2_valid    = 1'b0;
        clobber      = '0;
        flu_ready    = 1'b1;
        lsu_ready    = 1'b1;
        commit       = '0;
        for (int j = 0; j < 2**REG_ADDR_BITS; j++) shadow[j] = '0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            @(posedge clk_i);
            drive_cycle();
        end
        @(posedge clk_i);
        instr_valid <= 1'b0;
        commit      <= '0;
        repeat (3) @(posedge clk_i);
        $display("errors: ack=%0d addr=%0d fu_data=%0d pulse=%0d",
                 ack_errors, addr_errors, data_errors, pulse_errors);
        if (ack_errors + addr_errors + data_errors + pulse_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== list.f ====
source/issue_pkg.sv
source/int_regfile.sv
source/operand_hazard.sv
source/issue_ctrl.sv
source/operand_select.sv
source/issue_read_operands.sv
testbench/issue_read_operands_asserts.sv
testbench/tb_issue_read_operands.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_issue_read_operands
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
